//--- logic/coreTop.sv
`timescale 1ns/1ns

module coreTop (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input pipePkg::word_t instrPc,
	input pipePkg::word_t instrWord,
	output logic instrCredit,
	input logic resultCredit,
	output logic resultValid,
	output pipePkg::word_t resultPc,
	output pipePkg::regIdx_t resultDest,
	output pipePkg::word_t resultValue,
	output logic resultTaken,
	output pipePkg::word_t resultTarget,
	output logic resultReserved
);
	import pipePkg::*;
	import isaPkg::*;

	logic qValid;
	logic qPop;
	word_t qPc;
	word_t qWord;
	regIdx_t rdAddrA;
	regIdx_t rdAddrB;
	word_t rdDataA;
	word_t rdDataB;
	logic stall;

	// decode register
	logic dValid;
	word_t dPc;
	aluOpE dAluOp;
	word_t dOpA;
	word_t dOpB;
	regIdx_t dDest;
	logic dTaken;
	word_t dTarget;
	logic dReserved;

	// execute register
	logic eValid;
	word_t ePc;
	regIdx_t eDest;
	word_t eValue;
	logic eTaken;
	word_t eTarget;
	logic eReserved;

	// writeback
	logic wrEn;
	regIdx_t wrAddr;
	word_t wrData;

	instrQueue uQueue (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrPc(instrPc),
		.instrWord(instrWord),
		.qPop(qPop),
		.qValid(qValid),
		.qPc(qPc),
		.qWord(qWord),
		.instrCredit(instrCredit)
	);

	regFile uRegFile (
		.clk(clk),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	decodeStage uDecode (
		.clk(clk),
		.rstN(rstN),
		.qValid(qValid),
		.qPc(qPc),
		.qWord(qWord),
		.qPop(qPop),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.eValid(eValid),
		.eDest(eDest),
		.eValue(eValue),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.stall(stall),
		.dValid(dValid),
		.dPc(dPc),
		.dAluOp(dAluOp),
		.dOpA(dOpA),
		.dOpB(dOpB),
		.dDest(dDest),
		.dTaken(dTaken),
		.dTarget(dTarget),
		.dReserved(dReserved)
	);

	executeStage uExecute (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.dValid(dValid),
		.dPc(dPc),
		.dAluOp(dAluOp),
		.dOpA(dOpA),
		.dOpB(dOpB),
		.dDest(dDest),
		.dTaken(dTaken),
		.dTarget(dTarget),
		.dReserved(dReserved),
		.eValid(eValid),
		.ePc(ePc),
		.eDest(eDest),
		.eValue(eValue),
		.eTaken(eTaken),
		.eTarget(eTarget),
		.eReserved(eReserved)
	);

	resultStage uResult (
		.clk(clk),
		.rstN(rstN),
		.eValid(eValid),
		.ePc(ePc),
		.eDest(eDest),
		.eValue(eValue),
		.eTaken(eTaken),
		.eTarget(eTarget),
		.eReserved(eReserved),
		.stall(stall),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.resultCredit(resultCredit),
		.resultValid(resultValid),
		.resultPc(resultPc),
		.resultDest(resultDest),
		.resultValue(resultValue),
		.resultTaken(resultTaken),
		.resultTarget(resultTarget),
		.resultReserved(resultReserved)
	);

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
	input logic clk,
	input logic rstN,
	input logic qValid,
	input pipePkg::word_t qPc,
	input pipePkg::word_t qWord,
	output logic qPop,
	output pipePkg::regIdx_t rdAddrA,
	output pipePkg::regIdx_t rdAddrB,
	input pipePkg::word_t rdDataA,
	input pipePkg::word_t rdDataB,
	input logic eValid,
	input pipePkg::regIdx_t eDest,
	input pipePkg::word_t eValue,
	input logic wrEn,
	input pipePkg::regIdx_t wrAddr,
	input pipePkg::word_t wrData,
	input logic stall,
	output logic dValid,
	output pipePkg::word_t dPc,
	output isaPkg::aluOpE dAluOp,
	output pipePkg::word_t dOpA,
	output pipePkg::word_t dOpB,
	output pipePkg::regIdx_t dDest,
	output logic dTaken,
	output pipePkg::word_t dTarget,
	output logic dReserved
);
	import pipePkg::*;
	import isaPkg::*;

	opcodeE op;
	functE funct;
	regIdx_t rs;
	regIdx_t rt;
	regIdx_t rd;
	logic [4:0] shamt;
	logic [15:0] imm;
	logic [25:0] jumpField;
	word_t pcPlus4;
	word_t signImm;
	word_t zeroImm;
	word_t opA;
	word_t opB;
	word_t srcA;
	word_t srcB;
	aluOpE aluOp;
	branchKindE branchKind;
	regIdx_t dest;
	logic reserved;
	logic usesRs;
	logic usesRt;
	logic hazard;
	logic taken;
	word_t targetAddr;

	assign op = opcodeE'(qWord[OP_HI:OP_LO]);
	assign funct = functE'(qWord[FUNCT_HI:FUNCT_LO]);
	assign rs = qWord[RS_HI:RS_LO];
	assign rt = qWord[RT_HI:RT_LO];
	assign rd = qWord[RD_HI:RD_LO];
	assign shamt = qWord[SHAMT_HI:SHAMT_LO];
	assign imm = qWord[IMM_HI:IMM_LO];
	assign jumpField = qWord[TARGET_HI:TARGET_LO];

	assign pcPlus4 = qPc + 32'd4;
	assign signImm = {{16{imm[15]}}, imm};
	assign zeroImm = {16'h0000, imm};

	assign rdAddrA = rs;
	assign rdAddrB = rt;

	// the younger execute value wins over result
	assign opA = (rs != '0 && eValid && eDest == rs) ? eValue :
		(rs != '0 && wrEn && wrAddr == rs) ? wrData : rdDataA;
	assign opB = (rt != '0 && eValid && eDest == rt) ? eValue :
		(rt != '0 && wrEn && wrAddr == rt) ? wrData : rdDataB;

	always_comb begin
		aluOp = ALU_PASS;
		branchKind = BR_NONE;
		dest = '0;
		srcA = opA;
		srcB = '0;
		reserved = 1'b0;
		usesRs = 1'b0;
		usesRt = 1'b0;
		case (op)
			SPECIAL: begin
				dest = rd;
				usesRs = 1'b1;
				usesRt = 1'b1;
				srcB = opB;
				case (funct)
					ADDU: aluOp = ALU_ADD;
					SUBU: aluOp = ALU_SUB;
					AND: aluOp = ALU_AND;
					OR: aluOp = ALU_OR;
					XOR: aluOp = ALU_XOR;
					SLT: aluOp = ALU_SLT;
					SLL, SRL: begin
						// rt is shifted by the amount carried in operand B
						aluOp = (funct == SLL) ? ALU_SLL : ALU_SRL;
						srcA = opB;
						srcB = {27'b0, shamt};
					end
					default: begin
						reserved = 1'b1;
						dest = '0;
					end
				endcase
			end
			ADDIU: begin
				aluOp = ALU_ADD;
				dest = rt;
				usesRs = 1'b1;
				srcB = signImm;
			end
			ANDI: begin
				aluOp = ALU_AND;
				dest = rt;
				usesRs = 1'b1;
				srcB = zeroImm;
			end
			ORI: begin
				aluOp = ALU_OR;
				dest = rt;
				usesRs = 1'b1;
				srcB = zeroImm;
			end
			LUI: begin
				aluOp = ALU_LUI;
				dest = rt;
				srcB = zeroImm;
			end
			BEQ: begin
				branchKind = BR_EQ;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			BNE: begin
				branchKind = BR_NE;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			J: branchKind = BR_JUMP;
			default: reserved = 1'b1;
		endcase
	end

	// branches resolve here on forwarded operands
	always_comb begin
		taken = 1'b0;
		targetAddr = '0;
		case (branchKind)
			BR_EQ: begin
				taken = (opA == opB);
				targetAddr = pcPlus4 + {signImm[29:0], 2'b00};
			end
			BR_NE: begin
				taken = (opA != opB);
				targetAddr = pcPlus4 + {signImm[29:0], 2'b00};
			end
			BR_JUMP: begin
				taken = 1'b1;
				targetAddr = {pcPlus4[31:28], jumpField, 2'b00};
			end
			default: taken = 1'b0;
		endcase
	end

	// producer still in the decode register has no value to forward yet
	assign hazard = dValid && (dDest != '0) &&
		((usesRs && rs == dDest) || (usesRt && rt == dDest));

	assign qPop = qValid && !stall && !hazard;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dValid <= 1'b0;
		end else if (!stall) begin
			dValid <= qPop;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			dPc <= qPc;
			dAluOp <= aluOp;
			dOpA <= srcA;
			dOpB <= srcB;
			dDest <= dest;
			dTaken <= taken;
			dTarget <= targetAddr;
			dReserved <= reserved;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) stall |-> !qPop)
		else $error("queue popped while pipeline stalled");

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ns

module executeStage (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic dValid,
	input pipePkg::word_t dPc,
	input isaPkg::aluOpE dAluOp,
	input pipePkg::word_t dOpA,
	input pipePkg::word_t dOpB,
	input pipePkg::regIdx_t dDest,
	input logic dTaken,
	input pipePkg::word_t dTarget,
	input logic dReserved,
	output logic eValid,
	output pipePkg::word_t ePc,
	output pipePkg::regIdx_t eDest,
	output pipePkg::word_t eValue,
	output logic eTaken,
	output pipePkg::word_t eTarget,
	output logic eReserved
);
	import pipePkg::*;
	import isaPkg::*;

	word_t aluOut;

	always_comb begin
		case (dAluOp)
			ALU_ADD: aluOut = dOpA + dOpB;
			ALU_SUB: aluOut = dOpA - dOpB;
			ALU_AND: aluOut = dOpA & dOpB;
			ALU_OR: aluOut = dOpA | dOpB;
			ALU_XOR: aluOut = dOpA ^ dOpB;
			// signed compare
			ALU_SLT: aluOut = {31'b0, $signed(dOpA) < $signed(dOpB)};
			ALU_SLL: aluOut = dOpA << dOpB[4:0];
			ALU_SRL: aluOut = dOpA >> dOpB[4:0];
			ALU_LUI: aluOut = {dOpB[15:0], 16'h0000};
			// control and reserved carry zero in operand B
			ALU_PASS: aluOut = dOpB;
			default: aluOut = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			eValid <= 1'b0;
		end else if (!stall) begin
			eValid <= dValid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ePc <= dPc;
			eDest <= dDest;
			eValue <= aluOut;
			eTaken <= dTaken;
			eTarget <= dTarget;
			eReserved <= dReserved;
		end
	end

endmodule

//--- logic/instrQueue.sv
`timescale 1ns/1ns

module instrQueue (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input pipePkg::word_t instrPc,
	input pipePkg::word_t instrWord,
	input logic qPop,
	output logic qValid,
	output pipePkg::word_t qPc,
	output pipePkg::word_t qWord,
	output logic instrCredit
);
	import pipePkg::*;

	word_t pcMem [QUEUE_DEPTH];
	word_t wordMem [QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wrPtr;
	logic [QUEUE_PTR_W-1:0] rdPtr;
	creditCount_t count;
	logic pop;

	assign pop = qPop && qValid;
	assign qValid = (count != '0);
	assign qPc = pcMem[rdPtr];
	assign qWord = wordMem[rdPtr];

	// every freed slot hands one credit back to the source
	assign instrCredit = pop;

	always_ff @(posedge clk) begin
		if (instrValid) begin
			pcMem[wrPtr] <= instrPc;
			wordMem[wrPtr] <= instrWord;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (instrValid) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({instrValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// source spent a credit it did not hold
	assert property (@(posedge clk) disable iff (!rstN)
		instrValid |-> count != creditCount_t'(QUEUE_DEPTH))
		else $error("instruction written into full queue");

endmodule

//--- logic/isaPkg.sv
package isaPkg;

	// primary opcode, bits 31:26
	typedef enum logic [5:0] {
		SPECIAL = 6'h00,
		J       = 6'h02,
		BEQ     = 6'h04,
		BNE     = 6'h05,
		ADDIU   = 6'h09,
		ANDI    = 6'h0c,
		ORI     = 6'h0d,
		LUI     = 6'h0f
	} opcodeE;

	// function field of SPECIAL, bits 5:0
	typedef enum logic [5:0] {
		SLL  = 6'h00,
		SRL  = 6'h02,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		SLT  = 6'h2a
	} functE;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI,
		ALU_PASS
	} aluOpE;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JUMP
	} branchKindE;

	// instruction field positions
	localparam int OP_HI     = 31;
	localparam int OP_LO     = 26;
	localparam int RS_HI     = 25;
	localparam int RS_LO     = 21;
	localparam int RT_HI     = 20;
	localparam int RT_LO     = 16;
	localparam int RD_HI     = 15;
	localparam int RD_LO     = 11;
	localparam int SHAMT_HI  = 10;
	localparam int SHAMT_LO  = 6;
	localparam int FUNCT_HI  = 5;
	localparam int FUNCT_LO  = 0;
	localparam int IMM_HI    = 15;
	localparam int IMM_LO    = 0;
	localparam int TARGET_HI = 25;
	localparam int TARGET_LO = 0;

endpackage

//--- logic/pipePkg.sv
package pipePkg;

	localparam int WORD_W = 32;
	localparam int REG_COUNT = 32;

	// input queue size, equal to the credits the source starts with
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

	// output credits granted after reset
	localparam int RESULT_CREDITS = 2;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [$clog2(REG_COUNT)-1:0] regIdx_t;

	// wide enough for queue occupancy and output credits
	typedef logic [2:0] creditCount_t;

endpackage

//--- logic/regFile.sv
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input pipePkg::regIdx_t rdAddrA,
	input pipePkg::regIdx_t rdAddrB,
	output pipePkg::word_t rdDataA,
	output pipePkg::word_t rdDataB,
	input logic wrEn,
	input pipePkg::regIdx_t wrAddr,
	input pipePkg::word_t wrData
);
	import pipePkg::*;

	word_t regs [REG_COUNT];

	// r0 reads as zero, its storage is never written
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

	always_ff @(posedge clk) begin
		if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

//--- logic/resultStage.sv
`timescale 1ns/1ns

module resultStage (
	input logic clk,
	input logic rstN,
	input logic eValid,
	input pipePkg::word_t ePc,
	input pipePkg::regIdx_t eDest,
	input pipePkg::word_t eValue,
	input logic eTaken,
	input pipePkg::word_t eTarget,
	input logic eReserved,
	output logic stall,
	output logic wrEn,
	output pipePkg::regIdx_t wrAddr,
	output pipePkg::word_t wrData,
	input logic resultCredit,
	output logic resultValid,
	output pipePkg::word_t resultPc,
	output pipePkg::regIdx_t resultDest,
	output pipePkg::word_t resultValue,
	output logic resultTaken,
	output pipePkg::word_t resultTarget,
	output logic resultReserved
);
	import pipePkg::*;

	logic holdValid;
	creditCount_t credits;

	// record leaves only when a credit is there for it
	assign resultValid = holdValid && (credits != '0);
	assign stall = holdValid && (credits == '0);

	// one write per record, never for r0 or reserved
	assign wrEn = resultValid && (resultDest != '0) && !resultReserved;
	assign wrAddr = resultDest;
	assign wrData = resultValue;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			holdValid <= 1'b0;
		end else if (!stall) begin
			holdValid <= eValid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			resultPc <= ePc;
			resultDest <= eDest;
			resultValue <= eValue;
			resultTaken <= eTaken;
			resultTarget <= eTarget;
			resultReserved <= eReserved;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			credits <= creditCount_t'(RESULT_CREDITS);
		end else begin
			case ({resultCredit, resultValid})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// sink returned more credits than it was given
	assert property (@(posedge clk) disable iff (!rstN)
		credits <= creditCount_t'(RESULT_CREDITS))
		else $error("output credit counter overflow");

endmodule

//--- sim.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/instrQueue.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/resultStage.sv
logic/coreTop.sv
testbench/coreTb.sv

//--- testbench/coreTb.sv
`timescale 1ns/1ns

module coreTb;
	import pipePkg::*;

	localparam string CASE_FILE = "testbench/instrCases.txt";
	localparam int RESET_CYCLES = 5;
	localparam int CREDIT_TIMEOUT = 200;
	localparam int RESULT_TIMEOUT = 200;
	localparam int QUIET_CYCLES = 10;

	logic clk;
	logic rstN;
	logic instrValid;
	word_t instrPc;
	word_t instrWord;
	logic instrCredit;
	logic resultCredit;
	logic resultValid;
	word_t resultPc;
	regIdx_t resultDest;
	word_t resultValue;
	logic resultTaken;
	word_t resultTarget;
	logic resultReserved;

	// one entry per line of the case file
	word_t casePc[$];
	word_t caseWord[$];
	regIdx_t caseDest[$];
	word_t caseValue[$];
	logic caseTaken[$];
	word_t caseTarget[$];
	logic caseReserved[$];

	// case indices in the order they were sent
	int expQ[$];

	int creditsSpent = 0;
	int creditsReturned = 0;
	integer seed;

	coreTop UUT (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrPc(instrPc),
		.instrWord(instrWord),
		.instrCredit(instrCredit),
		.resultCredit(resultCredit),
		.resultValid(resultValid),
		.resultPc(resultPc),
		.resultDest(resultDest),
		.resultValue(resultValue),
		.resultTaken(resultTaken),
		.resultTarget(resultTarget),
		.resultReserved(resultReserved)
	);

	always #2 clk = ~clk;

	// input credits come back as one-cycle pulses
	always @(posedge clk) begin
		if (rstN && instrCredit) begin
			creditsReturned <= creditsReturned + 1;
		end
	end

	task automatic stopRun();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkWord(input string field, input word_t got, input word_t exp,
		input word_t pc);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s of pc %h is %h, expected %h",
				$time, field, pc, got, exp);
			stopRun();
		end
	endtask

	task automatic checkReg(input string field, input regIdx_t got, input regIdx_t exp,
		input word_t pc);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s of pc %h is %0d, expected %0d",
				$time, field, pc, got, exp);
			stopRun();
		end
	endtask

	task automatic loadCases();
		integer fd;
		integer code;
		string line;
		word_t pc;
		word_t instrW;
		regIdx_t dest;
		word_t value;
		logic taken;
		word_t target;
		logic reserved;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the case file %s", CASE_FILE);
			stopRun();
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			// skip comment and blank lines
			if (code > 0 && line[0] != "#" && line[0] != "\n") begin
				code = $sscanf(line, "%h %h %h %h %h %h %h",
					pc, instrW, dest, value, taken, target, reserved);
				if (code != 7) begin
					$display("Malformed line in the case file: %s", line);
					stopRun();
				end
				casePc.push_back(pc);
				caseWord.push_back(instrW);
				caseDest.push_back(dest);
				caseValue.push_back(value);
				caseTaken.push_back(taken);
				caseTarget.push_back(target);
				caseReserved.push_back(reserved);
			end
		end
		$fclose(fd);
		if (casePc.size() == 0) begin
			$display("The case file holds no instructions");
			stopRun();
		end
	endtask

	task automatic compareRecord(input int idx);
		word_t pc;
		pc = casePc[idx];
		checkWord("pc", resultPc, pc, pc);
		checkReg("dest", resultDest, caseDest[idx], pc);
		checkWord("value", resultValue, caseValue[idx], pc);
		// flags widened to a word
		checkWord("taken", {31'b0, resultTaken}, {31'b0, caseTaken[idx]}, pc);
		checkWord("target", resultTarget, caseTarget[idx], pc);
		checkWord("reserved", {31'b0, resultReserved}, {31'b0, caseReserved[idx]}, pc);
	endtask

	// drive one instruction per held input credit
	task automatic sendAll();
		int waitCycles;
		int available;
		for (int i = 0; i < casePc.size(); i++) begin
			waitCycles = 0;
			available = QUEUE_DEPTH + creditsReturned - creditsSpent;
			while (available == 0) begin
				instrValid = 1'b0;
				waitCycles++;
				if (waitCycles > CREDIT_TIMEOUT) begin
					$display("Timed out waiting for an input credit before case %0d", i);
					stopRun();
				end
				@(negedge clk);
				available = QUEUE_DEPTH + creditsReturned - creditsSpent;
			end
			if (available > QUEUE_DEPTH) begin
				$display("The queue returned more input credits than were spent");
				stopRun();
			end
			instrValid = 1'b1;
			instrPc = casePc[i];
			instrWord = caseWord[i];
			creditsSpent++;
			expQ.push_back(i);
			@(negedge clk);
		end
		instrValid = 1'b0;
	endtask

	// check records and return output credits after a random delay
	task automatic collectAll();
		int received;
		int idleCycles;
		int cycle;
		int idx;
		int delay;
		int dueQ[$];
		received = 0;
		idleCycles = 0;
		cycle = 0;
		while (received < casePc.size() || dueQ.size() > 0) begin
			@(negedge clk);
			cycle++;
			if (resultValid) begin
				if (expQ.size() == 0) begin
					$display("Result record for pc %h arrived with nothing outstanding",
						resultPc);
					stopRun();
				end
				idx = expQ.pop_front();
				compareRecord(idx);
				received++;
				idleCycles = 0;
				delay = $unsigned($random(seed)) % 4;
				dueQ.push_back(cycle + delay);
			end else begin
				idleCycles++;
				if (idleCycles > RESULT_TIMEOUT) begin
					$display("Timed out waiting for result record %0d", received);
					stopRun();
				end
			end
			resultCredit = 1'b0;
			if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
				resultCredit = 1'b1;
				void'(dueQ.pop_front());
			end
		end
		@(negedge clk);
		resultCredit = 1'b0;
	endtask

	// nothing may follow the last record
	task automatic checkQuiet();
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			if (resultValid) begin
				$display("Extra result record for pc %h after the trace ended", resultPc);
				stopRun();
			end
		end
	endtask

	task automatic waitCreditsBack();
		int waitCycles;
		waitCycles = 0;
		while (creditsReturned != creditsSpent) begin
			waitCycles++;
			if (waitCycles > CREDIT_TIMEOUT) begin
				$display("Timed out waiting for the queue to return all input credits");
				stopRun();
			end
			@(negedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instrPc = '0;
		instrWord = '0;
		resultCredit = 1'b0;
		seed = 93494;
		loadCases();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		fork
			sendAll();
			collectAll();
		join
		checkQuiet();
		waitCreditsBack();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- testbench/instrCases.txt
# pc instrWord dest value taken target reserved, all hex
# one instruction per line in trace order, dest 00 means no register write
10000000 24010005 01 00000005 0 00000000 0
10000004 2402FFFD 02 FFFFFFFD 0 00000000 0
10000008 00221821 03 00000002 0 00000000 0
1000000C 00612023 04 FFFFFFFD 0 00000000 0
10000010 0081282A 05 00000001 0 00000000 0
10000014 0024302A 06 00000000 0 00000000 0
10000018 3C078001 07 80010000 0 00000000 0
1000001C 34E78421 07 80018421 0 00000000 0
10000020 30E8FF0F 08 00008401 0 00000000 0
10000024 00074900 09 00184210 0 00000000 0
10000028 00075202 0A 00800184 0 00000000 0
1000002C 012A5826 0B 00984394 0 00000000 0
10000030 016A6024 0C 00800184 0 00000000 0
10000034 01816825 0D 00800185 0 00000000 0
10000038 10210003 00 00000000 1 10000048 0
1000003C 1421FFFE 00 00000000 0 10000038 0
10000040 15AC0010 00 00000000 1 10000084 0
10000044 08100040 00 00000000 1 10400100 0
10000048 8C01FFFF 00 00000000 0 00000000 1
1000004C 24200007 00 0000000C 0 00000000 0
10000050 00017021 0E 00000005 0 00000000 0
10000054 00017FC0 0F 80000000 0 00000000 0
10000058 000F87C2 10 00000001 0 00000000 0
